/* run.sh */
#!/bin/sh
# build with Verilator, then run and look for the pass line
verilator --binary --timing --assert -Wno-fatal -f sim.f \
  --top-module msi_ordering_tb -Mdir obj_dir &&
  ./obj_dir/Vmsi_ordering_tb | tee /dev/stderr | grep -qx "TEST PASSED" ||
  { echo "simulation did not pass"; exit 1; }

/* sim.f */
src/msi_ordering_pkg.sv
src/sync_fifo.sv
src/msi_vector_table.sv
src/flush_issuer.sv
src/write_response_tracker.sv
src/msi_release.sv
src/msi_ordering_top.sv
verification/clock_gen.sv
verification/msi_ordering_assertions.sv
verification/msi_ordering_tb.sv

/* src/flush_issuer.sv */
// ----------------------------
// pending flush write queue
// drives the F2H port
// ----------------------------
`timescale 1ns/1ps

module flush_issuer #(
  parameter int FLUSH_DEPTH = 16
) (
  input  var logic                        clk
 ,input  var logic                        rst
 ,input  var logic                        msi_accept
 ,input  var msi_ordering_pkg::axi_addr_t csr_flush_base
 ,input  var logic                        flush_ready
 ,output var logic                        flush_valid
 ,output var msi_ordering_pkg::axi_addr_t flush_addr
 ,output var logic                        full
);
  import msi_ordering_pkg::*;

  localparam int BASE_W = AXI_ADDR_W - VEC_W;

  logic [BASE_W-1:0] head_base;
  logic              empty;
  logic              flush_fire;

  // one token per MSI, the base as it was at acceptance
  sync_fifo #(
    .DEPTH (FLUSH_DEPTH)
   ,.WIDTH (BASE_W)
  ) flush_fifo_i (
    .clk     (clk)
   ,.rst     (rst)
   ,.push    (msi_accept)
   ,.pop     (flush_fire)
   ,.wr_data (csr_flush_base[AXI_ADDR_W-1:VEC_W])
   ,.rd_data (head_base)
   ,.empty   (empty)
   ,.full    (full)
  );

  assign flush_valid = ~empty;
  assign flush_fire  = flush_valid & flush_ready;
  // vector bits always zero on the flush
  assign flush_addr  = {head_base, {VEC_W{1'b0}}};

endmodule

/* src/msi_ordering_pkg.sv */
// ----------------------------
// widths, typedefs and packed structs
// shared by the MSI ordering bridge
// ----------------------------

package msi_ordering_pkg;

  localparam int NUM_VECTORS = 32;
  localparam int VEC_W       = 5;
  localparam int DATA_W      = 32;
  localparam int AXI_ADDR_W  = 36;
  localparam int AXI_ID_W    = 4;

  typedef logic [VEC_W-1:0]      vec_t;
  typedef logic [DATA_W-1:0]     msi_data_t;
  typedef logic [DATA_W/8-1:0]   byte_en_t;
  typedef logic [AXI_ADDR_W-1:0] axi_addr_t;
  typedef logic [7:0]            pend_cnt_t;

  // one MSI write as it arrives
  typedef struct packed {
    vec_t      vec;
    msi_data_t data;
    byte_en_t  byte_en;
  } msi_req_t;

  // message towards the GIC, data already masked
  typedef struct packed {
    vec_t      vec;
    msi_data_t data;
  } gic_msg_t;

  typedef struct packed {
    logic [AXI_ID_W-1:0] id;
    axi_addr_t           addr;
    logic [7:0]          len;
    logic [2:0]          prot;
  } aw_beat_t;

  typedef struct packed {
    logic [AXI_ID_W-1:0] id;
    logic [1:0]          resp;
  } b_beat_t;

endpackage

/* src/msi_ordering_top.sv */
// ----------------------------
// MSI ordering bridge top level
// ----------------------------
`timescale 1ns/1ps

module msi_ordering_top #(
  parameter int FLUSH_DEPTH = 16
 ,parameter int ORDER_DEPTH = 16
) (
  input  var logic                        clk
 ,input  var logic                        rst

  // MSI ingress
 ,input  var logic                        msi_valid
 ,input  var msi_ordering_pkg::msi_req_t  msi_req
 ,output var logic                        msi_ready

  // GIC egress
 ,output var logic                        gic_valid
 ,output var msi_ordering_pkg::gic_msg_t  gic_msg
 ,input  var logic                        gic_ready

  // F2H flush writes
 ,output var logic                        flush_valid
 ,output var msi_ordering_pkg::axi_addr_t flush_addr
 ,input  var logic                        flush_ready

  // snooped write address
 ,input  var logic                        in_aw_valid
 ,input  var msi_ordering_pkg::aw_beat_t  in_aw
 ,output var logic                        in_aw_ready
 ,output var logic                        out_aw_valid
 ,output var msi_ordering_pkg::aw_beat_t  out_aw
 ,input  var logic                        out_aw_ready

  // snooped write response
 ,input  var logic                        out_b_valid
 ,input  var msi_ordering_pkg::b_beat_t   out_b
 ,output var logic                        out_b_ready
 ,output var logic                        in_b_valid
 ,output var msi_ordering_pkg::b_beat_t   in_b
 ,input  var logic                        in_b_ready

  // low 5 bits ignored
 ,input  var msi_ordering_pkg::axi_addr_t csr_flush_base
);
  import msi_ordering_pkg::*;

  logic      msi_accept;
  logic      flush_full;
  logic      order_full;
  logic      head_clear;
  logic      head_pop;
  vec_t      rd_vec;
  msi_data_t table_data;

  assign msi_ready  = ~flush_full & ~order_full;
  assign msi_accept = msi_valid & msi_ready;

  msi_vector_table vector_table_i (
    .clk     (clk)
   ,.rst     (rst)
   ,.wr_en   (msi_accept)
   ,.wr_req  (msi_req)
   ,.rd_vec  (rd_vec)
   ,.rd_data (table_data)
  );

  flush_issuer #(
    .FLUSH_DEPTH (FLUSH_DEPTH)
  ) flush_issuer_i (
    .clk            (clk)
   ,.rst            (rst)
   ,.msi_accept     (msi_accept)
   ,.csr_flush_base (csr_flush_base)
   ,.flush_ready    (flush_ready)
   ,.flush_valid    (flush_valid)
   ,.flush_addr     (flush_addr)
   ,.full           (flush_full)
  );

  write_response_tracker #(
    .ORDER_DEPTH (ORDER_DEPTH)
  ) tracker_i (
    .clk            (clk)
   ,.rst            (rst)
   ,.csr_flush_base (csr_flush_base)
   ,.in_aw_valid    (in_aw_valid)
   ,.in_aw          (in_aw)
   ,.in_aw_ready    (in_aw_ready)
   ,.out_aw_valid   (out_aw_valid)
   ,.out_aw         (out_aw)
   ,.out_aw_ready   (out_aw_ready)
   ,.out_b_valid    (out_b_valid)
   ,.out_b          (out_b)
   ,.out_b_ready    (out_b_ready)
   ,.in_b_valid     (in_b_valid)
   ,.in_b           (in_b)
   ,.in_b_ready     (in_b_ready)
   ,.head_pop       (head_pop)
   ,.head_clear     (head_clear)
  );

  msi_release #(
    .ORDER_DEPTH (ORDER_DEPTH)
  ) release_i (
    .clk        (clk)
   ,.rst        (rst)
   ,.msi_accept (msi_accept)
   ,.msi_vec    (msi_req.vec)
   ,.table_data (table_data)
   ,.head_clear (head_clear)
   ,.gic_ready  (gic_ready)
   ,.rd_vec     (rd_vec)
   ,.gic_valid  (gic_valid)
   ,.gic_msg    (gic_msg)
   ,.head_pop   (head_pop)
   ,.full       (order_full)
  );

endmodule

/* src/msi_release.sv */
// ----------------------------
// MSI order queue
// releases to the GIC once the
// matching flush has cleared
// ----------------------------
`timescale 1ns/1ps

module msi_release #(
  parameter int ORDER_DEPTH = 16
) (
  input  var logic                        clk
 ,input  var logic                        rst
 ,input  var logic                        msi_accept
 ,input  var msi_ordering_pkg::vec_t      msi_vec
 ,input  var msi_ordering_pkg::msi_data_t table_data
 ,input  var logic                        head_clear
 ,input  var logic                        gic_ready
 ,output var msi_ordering_pkg::vec_t      rd_vec
 ,output var logic                        gic_valid
 ,output var msi_ordering_pkg::gic_msg_t  gic_msg
 ,output var logic                        head_pop
 ,output var logic                        full
);
  import msi_ordering_pkg::*;

  logic empty;

  // vectors kept in acceptance order
  sync_fifo #(
    .DEPTH (ORDER_DEPTH)
   ,.WIDTH (VEC_W)
  ) order_fifo_i (
    .clk     (clk)
   ,.rst     (rst)
   ,.push    (msi_accept)
   ,.pop     (head_pop)
   ,.wr_data (msi_vec)
   ,.rd_data (rd_vec)
   ,.empty   (empty)
   ,.full    (full)
  );

  // head may go out once its flush and all earlier writes are answered
  assign gic_valid = ~empty & head_clear;

  always_comb begin
    gic_msg.vec  = rd_vec;
    gic_msg.data = table_data;
  end

  // retires both the order entry and the tracker's pending entry
  assign head_pop = gic_valid & gic_ready;

endmodule

/* src/msi_vector_table.sv */
// ----------------------------
// per-vector MSI data storage
// with byte-enable masking
// ----------------------------
`timescale 1ns/1ps

module msi_vector_table (
  input  var logic                         clk
 ,input  var logic                         rst
 ,input  var logic                         wr_en
 ,input  var msi_ordering_pkg::msi_req_t   wr_req
 ,input  var msi_ordering_pkg::vec_t       rd_vec
 ,output var msi_ordering_pkg::msi_data_t  rd_data
);
  import msi_ordering_pkg::*;

  msi_data_t vec_data [NUM_VECTORS];
  msi_data_t masked_data;

  // disabled bytes are stored as zero
  always_comb begin
    for (int i = 0; i < DATA_W / 8; i++) begin
      masked_data[8*i +: 8] = wr_req.byte_en[i] ? wr_req.data[8*i +: 8] : 8'h00;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < NUM_VECTORS; i++) begin
        vec_data[i] <= '0;
      end
    end else if (wr_en) begin
      vec_data[wr_req.vec] <= masked_data;
    end
  end

  // last write per vector wins
  assign rd_data = vec_data[rd_vec];

endmodule

/* src/sync_fifo.sv */
// ----------------------------
// show-ahead synchronous FIFO
// count based, registered flags
// ----------------------------
`timescale 1ns/1ps

module sync_fifo #(
  parameter int DEPTH = 16
 ,parameter int WIDTH = 8
) (
  input  var logic             clk
 ,input  var logic             rst
 ,input  var logic             push
 ,input  var logic             pop
 ,input  var logic [WIDTH-1:0] wr_data
 ,output var logic [WIDTH-1:0] rd_data
 ,output var logic             empty
 ,output var logic             full
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  logic [WIDTH-1:0] mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic [CNT_W-1:0] count_next;
  logic             do_push;
  logic             do_pop;

  // push on full and pop on empty are dropped here
  assign do_push = push & ~full;
  assign do_pop  = pop & ~empty;

  // head word, valid whenever empty is low
  assign rd_data = mem[rd_ptr];

  always_comb begin
    count_next = count;
    if (do_push & ~do_pop) begin
      count_next = count + CNT_W'(1);
    end else if (do_pop & ~do_push) begin
      count_next = count - CNT_W'(1);
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
      empty  <= 1'b1;
      // full stays up through reset so nothing is pushed early
      full   <= 1'b1;
    end else begin
      if (do_push) begin
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + PTR_W'(1);
      end
      if (do_pop) begin
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + PTR_W'(1);
      end
      count <= count_next;
      empty <= (count_next == '0);
      full  <= (count_next == CNT_W'(DEPTH));
    end
  end

  always_ff @(posedge clk) begin
    if (do_push) begin
      mem[wr_ptr] <= wr_data;
    end
  end

endmodule

/* src/write_response_tracker.sv */
// ----------------------------
// AXI write address snoop
// outstanding write counter and
// per-flush pending response counts
// ----------------------------
`timescale 1ns/1ps

module write_response_tracker #(
  parameter int ORDER_DEPTH = 16
) (
  input  var logic                        clk
 ,input  var logic                        rst
 ,input  var msi_ordering_pkg::axi_addr_t csr_flush_base
 ,input  var logic                        in_aw_valid
 ,input  var msi_ordering_pkg::aw_beat_t  in_aw
 ,output var logic                        in_aw_ready
 ,output var logic                        out_aw_valid
 ,output var msi_ordering_pkg::aw_beat_t  out_aw
 ,input  var logic                        out_aw_ready
 ,input  var logic                        out_b_valid
 ,input  var msi_ordering_pkg::b_beat_t   out_b
 ,output var logic                        out_b_ready
 ,output var logic                        in_b_valid
 ,output var msi_ordering_pkg::b_beat_t   in_b
 ,input  var logic                        in_b_ready
 ,input  var logic                        head_pop
 ,output var logic                        head_clear
);
  import msi_ordering_pkg::*;

  localparam int PTR_W = (ORDER_DEPTH > 1) ? $clog2(ORDER_DEPTH) : 1;
  localparam int OCC_W = $clog2(ORDER_DEPTH + 1);

  pend_cnt_t        out_cnt;
  pend_cnt_t        pend [ORDER_DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [OCC_W-1:0] occ;
  logic             base_match;
  logic             pend_full;
  logic             aw_fire;
  logic             b_fire;
  logic             flush_fire;

  // ------------------------------
  // pass-through channels
  // ------------------------------
  assign base_match = in_aw.addr[AXI_ADDR_W-1:VEC_W] == csr_flush_base[AXI_ADDR_W-1:VEC_W];

  always_comb begin
    out_aw = in_aw;
    // strip the vector bits from a flushback
    if (base_match) begin
      out_aw.addr[VEC_W-1:0] = '0;
    end
  end

  assign out_aw_valid = in_aw_valid;
  assign pend_full    = (occ == OCC_W'(ORDER_DEPTH));
  assign in_aw_ready  = out_aw_ready & ~pend_full;

  assign in_b_valid  = out_b_valid;
  assign in_b        = out_b;
  assign out_b_ready = in_b_ready;

  assign aw_fire    = in_aw_valid & in_aw_ready;
  assign b_fire     = out_b_valid & out_b_ready;
  assign flush_fire = aw_fire & base_match;

  // ------------------------------
  // counters
  // ------------------------------
  always_ff @(posedge clk) begin
    if (rst) begin
      out_cnt    <= '0;
      wr_ptr     <= '0;
      rd_ptr     <= '0;
      occ        <= '0;
      head_clear <= 1'b0;
      for (int i = 0; i < ORDER_DEPTH; i++) begin
        pend[i] <= '0;
      end
    end else begin
      // any resp code counts as an answer
      if (aw_fire & ~b_fire) begin
        out_cnt <= out_cnt + pend_cnt_t'(1);
      end else if (b_fire & ~aw_fire & (out_cnt != '0)) begin
        out_cnt <= out_cnt - pend_cnt_t'(1);
      end

      for (int i = 0; i < ORDER_DEPTH; i++) begin
        if (flush_fire & (int'(wr_ptr) == i)) begin
          // earlier writes plus the flush itself, less a response landing now
          pend[i] <= b_fire ? out_cnt : out_cnt + pend_cnt_t'(1);
        end else if (b_fire & (pend[i] != '0)) begin
          pend[i] <= pend[i] - pend_cnt_t'(1);
        end
      end

      if (flush_fire) begin
        wr_ptr <= (wr_ptr == PTR_W'(ORDER_DEPTH - 1)) ? '0 : wr_ptr + PTR_W'(1);
      end
      if (head_pop) begin
        rd_ptr <= (rd_ptr == PTR_W'(ORDER_DEPTH - 1)) ? '0 : rd_ptr + PTR_W'(1);
      end
      occ <= occ + OCC_W'(flush_fire) - OCC_W'(head_pop);

      // dropped for a cycle after a pop so the next head is re-evaluated
      head_clear <= ~head_pop & (occ != '0) & (pend[rd_ptr] == '0);
    end
  end

endmodule

/* verification/clock_gen.sv */
// ----------------------------
// testbench clock and reset
// ----------------------------
`timescale 1ns/1ps

module clock_gen #(
  parameter int HALF_PERIOD  = 20
 ,parameter int RESET_CYCLES = 4
) (
  output var logic clk
 ,output var logic rst
);

  initial begin
    clk = 1'b0;
    forever #(HALF_PERIOD) clk = ~clk;
  end

  // reset released on a rising edge
  initial begin
    rst = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    rst <= 1'b0;
  end

endmodule

/* verification/msi_ordering_assertions.sv */
// ----------------------------
// handshake assertions, bound to the
// bridge top level
// ----------------------------
`timescale 1ns/1ps

module msi_ordering_assertions (
  input var logic                        clk
 ,input var logic                        rst
 ,input var logic                        gic_valid
 ,input var logic                        gic_ready
 ,input var msi_ordering_pkg::gic_msg_t  gic_msg
 ,input var logic                        flush_valid
 ,input var logic                        flush_ready
 ,input var msi_ordering_pkg::axi_addr_t flush_addr
 ,input var logic                        out_aw_valid
 ,input var logic                        out_aw_ready
 ,input var msi_ordering_pkg::aw_beat_t  out_aw
);

  // a stalled valid holds with its payload
  gic_hold_a : assert property (@(posedge clk) disable iff (rst)
    gic_valid && !gic_ready |=> gic_valid && $stable(gic_msg))
    else $error("gic_valid dropped or gic_msg changed while stalled");

  flush_hold_a : assert property (@(posedge clk) disable iff (rst)
    flush_valid && !flush_ready |=> flush_valid && $stable(flush_addr))
    else $error("flush_valid dropped or flush_addr changed while stalled");

  aw_hold_a : assert property (@(posedge clk) disable iff (rst)
    out_aw_valid && !out_aw_ready |=> out_aw_valid && $stable(out_aw))
    else $error("out_aw_valid dropped or out_aw changed while stalled");

endmodule

/* verification/msi_ordering_tb.sv */
// ----------------------------
// MSI ordering bridge testbench
// file driven stimulus, ordering model
// and checks
// ----------------------------
`timescale 1ns/1ps

module msi_ordering_tb;
  import msi_ordering_pkg::*;

  localparam axi_addr_t FLUSH_BASE = 36'h1_2345_6780;
  localparam int        TIMEOUT    = 400;

  logic      clk;
  logic      rst;
  logic      msi_valid;
  msi_req_t  msi_req;
  logic      msi_ready;
  logic      gic_valid;
  gic_msg_t  gic_msg;
  logic      gic_ready;
  logic      flush_valid;
  axi_addr_t flush_addr;
  logic      flush_ready;
  logic      in_aw_valid;
  aw_beat_t  in_aw;
  logic      in_aw_ready;
  logic      out_aw_valid;
  aw_beat_t  out_aw;
  logic      out_aw_ready;
  logic      out_b_valid;
  b_beat_t   out_b;
  logic      out_b_ready;
  logic      in_b_valid;
  b_beat_t   in_b;
  logic      in_b_ready;
  axi_addr_t csr_flush_base;

  // model state
  int        errors;
  int        test_start_errors;
  int        tests_passed;
  int        tests_failed;
  int        msi_count;
  int        flush_count;
  int        write_count;
  int        answered;
  int        released;
  int        flush_seq_q[$];
  axi_addr_t flush_seen_q[$];
  gic_msg_t  gic_out_q[$];
  logic [31:0]       gap_seed;
  logic [31:0]       ready_seed;
  logic              stall_req;
  logic              prev_stalled;
  gic_msg_t          prev_msg;
  logic [8*24-1:0]   test_name;
  logic              test_open;
  logic              aborted;

  clock_gen clock_gen_i (
    .clk (clk)
   ,.rst (rst)
  );

  msi_ordering_top #(
    .FLUSH_DEPTH (16)
   ,.ORDER_DEPTH (16)
  ) dut_i (.*);

  bind msi_ordering_top msi_ordering_assertions assertions_i (.*);

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  task automatic check_value(input logic [63:0] actual, input logic [63:0] expected,
                             input string what);
    if (actual !== expected) begin
      $display("[ERROR] %0t ns: %s, got %0h, expected %0h", $time, what, actual, expected);
      errors++;
    end
  endtask

  task automatic report_timeout(input string what);
    $display("timeout: %s", what);
    errors++;
    aborted = 1'b1;
  endtask

  task automatic close_test();
    if (test_open) begin
      if (errors == test_start_errors) begin
        tests_passed++;
        $display("test %0s: passed", test_name);
      end else begin
        tests_failed++;
        $display("test %0s: failed with %0d errors", test_name, errors - test_start_errors);
      end
    end
    test_open = 1'b0;
  endtask

  task automatic open_test(input logic [8*24-1:0] name);
    close_test();
    test_name         = name;
    test_open         = 1'b1;
    test_start_errors = errors;
  endtask

  task automatic idle_gap();
    gap_seed = lcg_next(gap_seed);
    repeat (gap_seed[17:16]) @(posedge clk);
  endtask

  task automatic check_reset();
    logic released_rst;
    int   i;
    released_rst = 1'b0;
    for (i = 0; i < TIMEOUT && !released_rst; i++) begin
      @(posedge clk);
      #1;
      check_value({gic_valid, flush_valid, msi_ready}, 3'b000, "outputs low around reset");
      released_rst = ~rst;
    end
    if (!released_rst) report_timeout("reset was never released");
  endtask

  task automatic send_msi(input logic [63:0] vec, input logic [63:0] data,
                          input logic [63:0] be);
    logic fired;
    int   i;
    @(posedge clk);
    #1;
    msi_valid       = 1'b1;
    msi_req.vec     = vec[VEC_W-1:0];
    msi_req.data    = data[DATA_W-1:0];
    msi_req.byte_en = be[3:0];
    fired = 1'b0;
    for (i = 0; i < TIMEOUT && !fired; i++) begin
      @(posedge clk);
      fired = msi_ready;
    end
    if (!fired) report_timeout("msi_ready never rose");
    #1;
    msi_valid = 1'b0;
  endtask

  task automatic send_aw(input axi_addr_t addr);
    aw_beat_t  beat;
    axi_addr_t exp_addr;
    logic      fired;
    int        i;
    gap_seed  = lcg_next(gap_seed);
    beat.id   = gap_seed[19:16];
    beat.addr = addr;
    beat.len  = gap_seed[27:20];
    beat.prot = gap_seed[30:28];
    // a base match leaves with its vector bits cleared
    exp_addr = addr;
    if (addr[AXI_ADDR_W-1:VEC_W] == FLUSH_BASE[AXI_ADDR_W-1:VEC_W]) begin
      exp_addr[VEC_W-1:0] = '0;
    end
    @(posedge clk);
    #1;
    in_aw_valid = 1'b1;
    in_aw       = beat;
    fired = 1'b0;
    for (i = 0; i < TIMEOUT && !fired; i++) begin
      @(posedge clk);
      fired = in_aw_ready;
      if (fired) begin
        check_value({out_aw_valid, out_aw_ready}, 2'b11, "out_aw handshake");
        check_value(out_aw.addr, exp_addr, "out_aw address");
        check_value({out_aw.id, out_aw.len, out_aw.prot}, {beat.id, beat.len, beat.prot},
                    "out_aw id, len and prot");
      end
    end
    if (!fired) report_timeout("in_aw_ready never rose");
    #1;
    in_aw_valid = 1'b0;
  endtask

  task automatic replay_flush(input logic [63:0] vec);
    axi_addr_t addr;
    int        i;
    for (i = 0; i < TIMEOUT && flush_seen_q.size() == 0; i++) begin
      @(posedge clk);
    end
    if (flush_seen_q.size() == 0) begin
      report_timeout("no flush write to replay");
    end else begin
      addr = flush_seen_q.pop_front();
      send_aw(addr | axi_addr_t'(vec[VEC_W-1:0]));
    end
  endtask

  task automatic send_b();
    b_beat_t beat;
    logic    fired;
    int      i;
    gap_seed  = lcg_next(gap_seed);
    beat.id   = gap_seed[19:16];
    beat.resp = gap_seed[21:20];
    @(posedge clk);
    #1;
    out_b_valid = 1'b1;
    out_b       = beat;
    fired = 1'b0;
    for (i = 0; i < TIMEOUT && !fired; i++) begin
      @(posedge clk);
      fired = out_b_ready;
      if (fired) begin
        check_value({in_b_valid, in_b_ready, in_b}, {2'b11, beat},
                    "write response pass-through");
      end
    end
    if (!fired) report_timeout("out_b_ready never rose");
    #1;
    out_b_valid = 1'b0;
  endtask

  task automatic stall_gic(input logic [63:0] cycles);
    @(posedge clk);
    stall_req = 1'b1;
    repeat (cycles[15:0]) @(posedge clk);
    stall_req = 1'b0;
  endtask

  task automatic expect_gic(input logic [63:0] vec, input logic [63:0] data);
    gic_msg_t msg;
    int       i;
    for (i = 0; i < TIMEOUT && gic_out_q.size() == 0; i++) begin
      @(posedge clk);
    end
    if (gic_out_q.size() == 0) begin
      report_timeout("no message released to the GIC");
    end else begin
      msg = gic_out_q.pop_front();
      check_value(msg.vec, vec[VEC_W-1:0], "gic vector");
      check_value(msg.data, data[DATA_W-1:0], "gic data");
    end
  endtask

  // ----------------------------
  // ready generation
  // ----------------------------
  always @(posedge clk) begin
    #1;
    ready_seed   = lcg_next(ready_seed);
    gic_ready    = ~stall_req & ready_seed[16];
    flush_ready  = ready_seed[17] | ready_seed[18];
    out_aw_ready = ready_seed[19] | ready_seed[20];
    in_b_ready   = ready_seed[21] | ready_seed[22];
  end

  // ----------------------------
  // monitor and ordering model
  // ----------------------------
  always @(posedge clk) begin
    if (!rst) begin
      // head needs its flushback and every write up to it answered
      if (gic_valid) begin
        check_value(released < flush_seq_q.size(), 1'b1, "gic_valid before flushback");
        if (released < flush_seq_q.size()) begin
          check_value(answered > flush_seq_q[released], 1'b1,
                      "gic_valid before earlier writes answered");
        end
      end
      if (prev_stalled) begin
        check_value({gic_valid, gic_msg}, {1'b1, prev_msg}, "gic payload held while stalled");
      end
      prev_stalled = gic_valid & ~gic_ready;
      prev_msg     = gic_msg;
      if (gic_valid & gic_ready) begin
        gic_out_q.push_back(gic_msg);
        released++;
      end
      if (msi_valid & msi_ready) msi_count++;
      if (flush_valid & flush_ready) begin
        check_value(flush_addr, {FLUSH_BASE[AXI_ADDR_W-1:VEC_W], 5'b0}, "flush address");
        flush_seen_q.push_back(flush_addr);
        flush_count++;
      end
      if (in_aw_valid & in_aw_ready) begin
        if (in_aw.addr[AXI_ADDR_W-1:VEC_W] == FLUSH_BASE[AXI_ADDR_W-1:VEC_W]) begin
          flush_seq_q.push_back(write_count);
        end
        write_count++;
      end
      if (out_b_valid & out_b_ready) answered++;
    end
  end

  initial begin
    int              fd;
    int              r;
    string           line;
    logic [8*12-1:0] op;
    logic [8*24-1:0] name;
    logic [63:0]     a1;
    logic [63:0]     a2;
    logic [63:0]     a3;
    msi_valid      = 1'b0;
    msi_req        = '0;
    gic_ready      = 1'b0;
    flush_ready    = 1'b0;
    in_aw_valid    = 1'b0;
    in_aw          = '0;
    out_aw_ready   = 1'b1;
    out_b_valid    = 1'b0;
    out_b          = '0;
    in_b_ready     = 1'b1;
    csr_flush_base = FLUSH_BASE;
    gap_seed       = 32'd48;
    ready_seed     = 32'd48;
    stall_req      = 1'b0;
    prev_stalled   = 1'b0;
    prev_msg       = '0;
    test_open      = 1'b0;
    aborted        = 1'b0;
    fd             = 0;
    open_test("reset");
    check_reset();
    if (!aborted) begin
      fd = $fopen("verification/msi_stimulus.txt", "r");
      if (fd == 0) begin
        $display("could not open the stimulus file verification/msi_stimulus.txt");
        errors++;
      end
    end
    if (fd != 0) begin
      while (!$feof(fd) && !aborted) begin
        r = $fgets(line, fd);
        if (r <= 0 || line.len() < 2 || line[0] == 8'h23) continue;
        op = '0;
        a1 = '0;
        a2 = '0;
        a3 = '0;
        r = $sscanf(line, "%s %h %h %h", op, a1, a2, a3);
        if (op == "test") begin
          r = $sscanf(line, "%s %s", op, name);
          open_test(name);
          continue;
        end
        idle_gap();
        if (op == "msi") send_msi(a1, a2, a3);
        else if (op == "aw") send_aw(a1[AXI_ADDR_W-1:0]);
        else if (op == "flushback") replay_flush(a1);
        else if (op == "b") send_b();
        else if (op == "gic_stall") stall_gic(a1);
        else if (op == "expect") expect_gic(a1, a2);
        else begin
          $display("unknown stimulus operation: %0s", op);
          errors++;
        end
      end
      $fclose(fd);
    end
    if (!aborted) begin
      check_value(flush_count, msi_count, "one flush per accepted MSI");
      check_value(released, msi_count, "every MSI released");
    end
    close_test();
    $display("tests passed %0d, tests failed %0d, errors %0d", tests_passed, tests_failed, errors);
    if (errors == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

/* verification/msi_stimulus.txt */
# one operation per line, arguments in hex
# test <name> | msi <vec> <data> <byte_en> | aw <addr> | flushback <vec>
# b | gic_stall <cycles> | expect <vec> <masked data>
test masking
msi 03 deadbeef 5
flushback 03
b
expect 03 00ad00ef
test ordering
aw 200001000
aw 200002040
msi 11 12345678 f
flushback 11
b
b
gic_stall 8
b
expect 11 12345678
test backpressure
msi 01 aabbccdd 3
msi 02 11223344 c
msi 1f cafef00d f
flushback 01
flushback 02
flushback 1f
aw 300000010
b
b
b
b
expect 01 0000ccdd
expect 02 11220000
expect 1f cafef00d
